// ==== verilog/priv_pkg.sv ====
package priv_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_word_t;

  typedef enum logic [1:0] {
    U_MODE = 2'd0,
    S_MODE = 2'd1,
    M_MODE = 2'd3
  } priv_level_t;

  // CSRRW, CSRRS and CSRRC
  typedef enum logic [1:0] {
    CSR_RW = 2'd0,
    CSR_RS = 2'd1,
    CSR_RC = 2'd2
  } csr_op_t;

  // Machine trap setup
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;

  // Machine trap handling
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;

  // Counter low and high halves
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;

  // Read-only machine information
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;

endpackage

// ==== verilog/machine_csr_file.sv ====
`timescale 1ns/100ps

module machine_csr_file #(
  parameter priv_pkg::csr_word_t HARTID = 32'd0
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  priv_pkg::csr_addr_t   bus_addr,
  input  priv_pkg::priv_level_t bus_priv,
  input  logic                  bus_wen,
  input  priv_pkg::csr_word_t   bus_wdata,
  input  logic                  inst_ret,
  output priv_pkg::csr_word_t   bus_rdata,
  output logic                  bus_invalid
);
  import priv_pkg::*;

  localparam csr_word_t MISA_VALUE = 32'h4000_1100; // MXL 1 with I and M

  logic        st_mie;
  logic        st_mpie;
  priv_level_t st_mpp;
  logic        st_mprv;
  logic        st_tw;
  logic [2:0]  ie_bits;  // meie, mtie, msie
  logic [2:0]  ip_bits;  // meip, mtip, msip
  logic [29:0] mtvec_base;
  logic [1:0]  mtvec_mode;
  csr_word_t   mscratch;
  csr_word_t   mepc;
  csr_word_t   mcause;
  csr_word_t   mtval;
  csr_word_t   mcounteren;
  csr_word_t   mcountinhibit;
  logic [63:0] cycle_count;
  logic [63:0] instret_count;

  csr_word_t   mstatus_val;
  csr_word_t   legal_wdata;
  logic        known;
  logic        csr_write;

  // Interrupt bits sit at 11, 7 and 3
  function automatic csr_word_t irq_word(input logic [2:0] bits);
    return {20'd0, bits[2], 3'd0, bits[1], 3'd0, bits[0], 3'd0};
  endfunction

  assign mstatus_val = {10'd0, st_tw, 3'd0, st_mprv, 4'd0, st_mpp,
                        3'd0, st_mpie, 3'd0, st_mie, 3'd0};

  // Fix up WARL fields before they are stored
  always_comb begin
    legal_wdata = bus_wdata;
    if (bus_addr == MSTATUS_ADDR && bus_wdata[12:11] == 2'b10) begin
      legal_wdata[12:11] = 2'b00; // Reserved mpp level falls back to U
    end
    if (bus_addr == MTVEC_ADDR && bus_wdata[1:0] > 2'b01) begin
      legal_wdata[1:0] = 2'b00;   // Only direct and vectored
    end
  end

  always_comb begin
    bus_rdata = '0;
    known     = 1'b1;
    case (bus_addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR: bus_rdata = '0;
      MHARTID_ADDR:       bus_rdata = HARTID;
      MSTATUS_ADDR:       bus_rdata = mstatus_val;
      MISA_ADDR:          bus_rdata = MISA_VALUE;
      MIE_ADDR:           bus_rdata = irq_word(ie_bits);
      MIP_ADDR:           bus_rdata = irq_word(ip_bits);
      MTVEC_ADDR:         bus_rdata = {mtvec_base, mtvec_mode};
      MSCRATCH_ADDR:      bus_rdata = mscratch;
      MEPC_ADDR:          bus_rdata = mepc;
      MCAUSE_ADDR:        bus_rdata = mcause;
      MTVAL_ADDR:         bus_rdata = mtval;
      MCOUNTEREN_ADDR:    bus_rdata = mcounteren;
      MCOUNTINHIBIT_ADDR: bus_rdata = mcountinhibit;
      MCYCLE_ADDR:        bus_rdata = cycle_count[31:0];
      MCYCLEH_ADDR:       bus_rdata = cycle_count[63:32];
      MINSTRET_ADDR:      bus_rdata = instret_count[31:0];
      MINSTRETH_ADDR:     bus_rdata = instret_count[63:32];
      default:            known = 1'b0;
    endcase
  end

  // Privilege field above the caller, unknown CSR, or write to a read-only one
  assign bus_invalid = ~known | (bus_addr[9:8] > bus_priv) | (bus_wen & (&bus_addr[11:10]));
  assign csr_write   = bus_wen & ~bus_invalid;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      st_mie        <= 1'b0;
      st_mpie       <= 1'b0;
      st_mpp        <= M_MODE;
      st_mprv       <= 1'b0;
      st_tw         <= 1'b1;
      ie_bits       <= '0;
      ip_bits       <= '0;
      mtvec_base    <= '0;
      mtvec_mode    <= 2'b00;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '1;
      mcountinhibit <= '1;  // Counters start stopped
    end else if (csr_write) begin
      case (bus_addr)
        MSTATUS_ADDR: begin
          st_mie  <= legal_wdata[3];
          st_mpie <= legal_wdata[7];
          st_mpp  <= priv_level_t'(legal_wdata[12:11]);
          st_mprv <= legal_wdata[17];
          st_tw   <= legal_wdata[21];
        end
        MTVEC_ADDR: begin
          mtvec_base <= legal_wdata[31:2];
          mtvec_mode <= legal_wdata[1:0];
        end
        MIE_ADDR:           ie_bits <= {legal_wdata[11], legal_wdata[7], legal_wdata[3]};
        MIP_ADDR:           ip_bits <= {legal_wdata[11], legal_wdata[7], legal_wdata[3]};
        MSCRATCH_ADDR:      mscratch <= legal_wdata;
        MEPC_ADDR:          mepc <= legal_wdata;
        MCAUSE_ADDR:        mcause <= legal_wdata;
        MTVAL_ADDR:         mtval <= legal_wdata;
        MCOUNTEREN_ADDR:    mcounteren <= legal_wdata;
        MCOUNTINHIBIT_ADDR: mcountinhibit <= legal_wdata;
        default: ;
      endcase
    end
  end

  // Inhibit bit 0 stops mcycle and bit 2 stops minstret
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cycle_count   <= '0;
      instret_count <= '0;
    end else begin
      if (!mcountinhibit[0]) begin
        cycle_count <= cycle_count + 64'd1;
      end
      if (!mcountinhibit[2]) begin
        instret_count <= instret_count + 64'(inst_ret);
      end
    end
  end

endmodule

// ==== verilog/csr_op_unit.sv ====
`timescale 1ns/100ps

module csr_op_unit (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  instr_valid,
  output logic                  instr_ready,
  input  priv_pkg::csr_op_t     instr_op,
  input  priv_pkg::csr_addr_t   instr_addr,
  input  priv_pkg::csr_word_t   instr_operand,
  input  priv_pkg::priv_level_t instr_priv,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output priv_pkg::csr_word_t   resp_old,
  output logic                  resp_illegal,
  output logic                  op_req,
  input  logic                  op_gnt,
  output priv_pkg::csr_addr_t   op_addr,
  output logic                  op_wen,
  output priv_pkg::csr_word_t   op_wdata,
  output priv_pkg::priv_level_t op_priv,
  input  priv_pkg::csr_word_t   bus_rdata,
  input  logic                  bus_invalid
);
  import priv_pkg::*;

  logic      held;          // Instruction waiting for the bus
  csr_op_t   held_op;
  csr_word_t held_operand;

  assign instr_ready = ~held & ~resp_valid;
  assign op_req      = held;

  // Set and clear only write when some bit would change
  assign op_wen = (held_op == CSR_RW) | (|held_operand);

  always_comb begin
    case (held_op)
      CSR_RS:  op_wdata = bus_rdata | held_operand;
      CSR_RC:  op_wdata = bus_rdata & ~held_operand;
      default: op_wdata = held_operand;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      held       <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      if (instr_valid && instr_ready) begin
        held <= 1'b1;
      end else if (op_gnt) begin
        held       <= 1'b0;
        resp_valid <= 1'b1;  // Response one cycle after the grant
      end
      if (resp_valid && resp_ready) begin
        resp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (instr_valid && instr_ready) begin
      held_op      <= instr_op;
      held_operand <= instr_operand;
      op_addr      <= instr_addr;
      op_priv      <= instr_priv;
    end
    if (op_gnt) begin
      resp_old     <= bus_rdata;
      resp_illegal <= bus_invalid;
    end
  end

endmodule

// ==== verilog/trap_sequencer.sv ====
`timescale 1ns/100ps

module trap_sequencer (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                trap_valid,
  output logic                trap_ready,
  input  priv_pkg::csr_word_t trap_epc,
  input  priv_pkg::csr_word_t trap_cause,
  output logic                target_valid,
  input  logic                target_ready,
  output priv_pkg::csr_word_t target_pc,
  output logic                trap_req,
  input  logic                trap_gnt,
  output priv_pkg::csr_addr_t trap_addr,
  output logic                trap_wen,
  output priv_pkg::csr_word_t trap_wdata,
  input  priv_pkg::csr_word_t bus_rdata
);
  import priv_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SAVE_EPC,
    SAVE_CAUSE,
    UPDATE_STATUS,
    READ_VECTOR,
    RESPOND
  } trap_state_t;

  trap_state_t state;
  csr_word_t   saved_epc;
  csr_word_t   saved_cause;
  csr_word_t   handler_pc;

  assign trap_ready   = (state == IDLE);
  assign target_valid = (state == RESPOND);
  assign trap_req     = (state != IDLE) && (state != RESPOND);

  always_comb begin
    trap_addr  = MTVEC_ADDR;
    trap_wen   = 1'b0;
    trap_wdata = saved_epc;
    case (state)
      SAVE_EPC: begin
        trap_addr = MEPC_ADDR;
        trap_wen  = 1'b1;
      end
      SAVE_CAUSE: begin
        trap_addr  = MCAUSE_ADDR;
        trap_wen   = 1'b1;
        trap_wdata = saved_cause;
      end
      UPDATE_STATUS: begin  // mpie takes the old mie and mie is cleared
        trap_addr     = MSTATUS_ADDR;
        trap_wen      = 1'b1;
        trap_wdata    = bus_rdata;
        trap_wdata[7] = bus_rdata[3];
        trap_wdata[3] = 1'b0;
      end
      default: ;
    endcase
  end

  // Vectored mode only applies to interrupts
  always_comb begin
    handler_pc = {bus_rdata[31:2], 2'b00};
    if (bus_rdata[1:0] == 2'b01 && saved_cause[31]) begin
      handler_pc = handler_pc + {saved_cause[29:0], 2'b00};
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:          if (trap_valid) state <= SAVE_EPC;
        SAVE_EPC:      if (trap_gnt) state <= SAVE_CAUSE;
        SAVE_CAUSE:    if (trap_gnt) state <= UPDATE_STATUS;
        UPDATE_STATUS: if (trap_gnt) state <= READ_VECTOR;
        READ_VECTOR:   if (trap_gnt) state <= RESPOND;
        RESPOND:       if (target_ready) state <= IDLE;
        default:       state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (trap_valid && trap_ready) begin
      saved_epc   <= trap_epc;
      saved_cause <= trap_cause;
    end
    if (state == READ_VECTOR && trap_gnt) begin
      target_pc <= handler_pc;  // mtvec is on the bus this cycle
    end
  end

endmodule

// ==== verilog/csr_arbiter.sv ====
`timescale 1ns/100ps

module csr_arbiter (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  op_req,
  input  priv_pkg::csr_addr_t   op_addr,
  input  logic                  op_wen,
  input  priv_pkg::csr_word_t   op_wdata,
  input  priv_pkg::priv_level_t op_priv,
  output logic                  op_gnt,
  input  logic                  trap_req,
  input  priv_pkg::csr_addr_t   trap_addr,
  input  logic                  trap_wen,
  input  priv_pkg::csr_word_t   trap_wdata,
  output logic                  trap_gnt,
  output priv_pkg::csr_addr_t   bus_addr,
  output priv_pkg::priv_level_t bus_priv,
  output logic                  bus_wen,
  output priv_pkg::csr_word_t   bus_wdata
);
  import priv_pkg::*;

  logic last_trap;  // Trap port held the previous grant

  always_comb begin
    if (op_req && trap_req) begin
      op_gnt   = last_trap;
      trap_gnt = ~last_trap;
    end else begin
      op_gnt   = op_req;
      trap_gnt = trap_req;
    end
  end

  // Traps always run at machine level
  assign bus_addr  = trap_gnt ? trap_addr  : op_addr;
  assign bus_priv  = trap_gnt ? M_MODE     : op_priv;
  assign bus_wdata = trap_gnt ? trap_wdata : op_wdata;
  assign bus_wen   = (trap_gnt & trap_wen) | (op_gnt & op_wen);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      last_trap <= 1'b0;
    end else if (op_gnt || trap_gnt) begin
      last_trap <= trap_gnt;
    end
  end

endmodule

// ==== verilog/priv_unit.sv ====
`timescale 1ns/100ps

module priv_unit #(
  parameter priv_pkg::csr_word_t HARTID = 32'd0
) (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  instr_valid,
  output logic                  instr_ready,
  input  priv_pkg::csr_op_t     instr_op,
  input  priv_pkg::csr_addr_t   instr_addr,
  input  priv_pkg::csr_word_t   instr_operand,
  input  priv_pkg::priv_level_t instr_priv,
  output logic                  resp_valid,
  input  logic                  resp_ready,
  output priv_pkg::csr_word_t   resp_old,
  output logic                  resp_illegal,
  input  logic                  trap_valid,
  output logic                  trap_ready,
  input  priv_pkg::csr_word_t   trap_epc,
  input  priv_pkg::csr_word_t   trap_cause,
  output logic                  target_valid,
  input  logic                  target_ready,
  output priv_pkg::csr_word_t   target_pc,
  input  logic                  inst_ret
);
  import priv_pkg::*;

  logic        op_req, op_gnt, op_wen;
  csr_addr_t   op_addr;
  csr_word_t   op_wdata;
  priv_level_t op_priv;
  logic        trap_req, trap_gnt, trap_wen;
  csr_addr_t   trap_addr;
  csr_word_t   trap_wdata;

  // Shared CSR bus
  csr_addr_t   bus_addr;
  priv_level_t bus_priv;
  logic        bus_wen, bus_invalid;
  csr_word_t   bus_wdata, bus_rdata;

  csr_op_unit op_unit0 (
    .CLK(CLK), .nRST(nRST),
    .instr_valid(instr_valid), .instr_ready(instr_ready), .instr_op(instr_op),
    .instr_addr(instr_addr), .instr_operand(instr_operand), .instr_priv(instr_priv),
    .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_old(resp_old),
    .resp_illegal(resp_illegal),
    .op_req(op_req), .op_gnt(op_gnt), .op_addr(op_addr), .op_wen(op_wen),
    .op_wdata(op_wdata), .op_priv(op_priv),
    .bus_rdata(bus_rdata), .bus_invalid(bus_invalid)
  );

  trap_sequencer trap_seq0 (
    .CLK(CLK), .nRST(nRST),
    .trap_valid(trap_valid), .trap_ready(trap_ready), .trap_epc(trap_epc),
    .trap_cause(trap_cause),
    .target_valid(target_valid), .target_ready(target_ready), .target_pc(target_pc),
    .trap_req(trap_req), .trap_gnt(trap_gnt), .trap_addr(trap_addr),
    .trap_wen(trap_wen), .trap_wdata(trap_wdata), .bus_rdata(bus_rdata)
  );

  csr_arbiter arb0 (
    .CLK(CLK), .nRST(nRST),
    .op_req(op_req), .op_addr(op_addr), .op_wen(op_wen), .op_wdata(op_wdata),
    .op_priv(op_priv), .op_gnt(op_gnt),
    .trap_req(trap_req), .trap_addr(trap_addr), .trap_wen(trap_wen),
    .trap_wdata(trap_wdata), .trap_gnt(trap_gnt),
    .bus_addr(bus_addr), .bus_priv(bus_priv), .bus_wen(bus_wen), .bus_wdata(bus_wdata)
  );

  machine_csr_file #(.HARTID(HARTID)) csr_file0 (
    .CLK(CLK), .nRST(nRST),
    .bus_addr(bus_addr), .bus_priv(bus_priv), .bus_wen(bus_wen),
    .bus_wdata(bus_wdata), .inst_ret(inst_ret),
    .bus_rdata(bus_rdata), .bus_invalid(bus_invalid)
  );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;  // Release on a rising edge
  end

endmodule

// ==== tb/tb_priv_unit.sv ====
`timescale 1ns/100ps

module tb_priv_unit;
  import priv_pkg::*;

  localparam int          PERIOD        = 40;
  localparam int          OPS           = 300;
  localparam int          CYCLES_PER_OP = 40;
  localparam logic [31:0] SEED          = 32'hcae87c8d;
  localparam csr_word_t   STATUS_MASK   = 32'h0022_1888;  // tw, mprv, mpp, mpie, mie
  localparam csr_word_t   IRQ_MASK      = 32'h0000_0888;  // meie, mtie, msie

  logic        CLK;
  logic        nRST;
  logic        instr_valid;
  logic        instr_ready;
  csr_op_t     instr_op;
  csr_addr_t   instr_addr;
  csr_word_t   instr_operand;
  priv_level_t instr_priv;
  logic        resp_valid;
  logic        resp_ready;
  csr_word_t   resp_old;
  logic        resp_illegal;
  logic        trap_valid;
  logic        trap_ready;
  csr_word_t   trap_epc;
  csr_word_t   trap_cause;
  logic        target_valid;
  logic        target_ready;
  csr_word_t   target_pc;
  logic        inst_ret;

  // Reference copy of the writable machine CSRs
  csr_word_t m_mstatus, m_mie, m_mip, m_mtvec, m_mscratch;
  csr_word_t m_mepc, m_mcause, m_mtval, m_mcounteren, m_mcountinhibit;
  int        err_value, err_flag, err_target, err_counter;

  tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(16)) clock0 (.CLK(CLK), .nRST(nRST));

  priv_unit #(.HARTID(32'd5)) dut0 (
    .CLK(CLK), .nRST(nRST),
    .instr_valid(instr_valid), .instr_ready(instr_ready), .instr_op(instr_op),
    .instr_addr(instr_addr), .instr_operand(instr_operand), .instr_priv(instr_priv),
    .resp_valid(resp_valid), .resp_ready(resp_ready), .resp_old(resp_old),
    .resp_illegal(resp_illegal),
    .trap_valid(trap_valid), .trap_ready(trap_ready), .trap_epc(trap_epc),
    .trap_cause(trap_cause),
    .target_valid(target_valid), .target_ready(target_ready), .target_pc(target_pc),
    .inst_ret(inst_ret)
  );

  function automatic csr_word_t model_read(input csr_addr_t a);
    case (a)
      MSTATUS_ADDR:       return m_mstatus;
      MISA_ADDR:          return 32'h4000_1100;  // RV32 with I and M
      MIE_ADDR:           return m_mie;
      MIP_ADDR:           return m_mip;
      MTVEC_ADDR:         return m_mtvec;
      MSCRATCH_ADDR:      return m_mscratch;
      MEPC_ADDR:          return m_mepc;
      MCAUSE_ADDR:        return m_mcause;
      MTVAL_ADDR:         return m_mtval;
      MCOUNTEREN_ADDR:    return m_mcounteren;
      MCOUNTINHIBIT_ADDR: return m_mcountinhibit;
      MHARTID_ADDR:       return 32'd5;
      default:            return '0;
    endcase
  endfunction

  function automatic logic model_known(input csr_addr_t a);
    case (a)
      MSTATUS_ADDR, MISA_ADDR, MIE_ADDR, MTVEC_ADDR, MCOUNTEREN_ADDR,
      MCOUNTINHIBIT_ADDR, MSCRATCH_ADDR, MEPC_ADDR, MCAUSE_ADDR, MTVAL_ADDR,
      MIP_ADDR, MCYCLE_ADDR, MCYCLEH_ADDR, MINSTRET_ADDR, MINSTRETH_ADDR,
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MHARTID_ADDR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Reserved mpp goes to U and an mtvec mode above vectored goes to direct
  task automatic model_write(input csr_addr_t a, input csr_word_t v);
    case (a)
      MSTATUS_ADDR: begin
        m_mstatus = v & STATUS_MASK;
        if (v[12:11] == 2'b10) m_mstatus[12:11] = 2'b00;
      end
      MTVEC_ADDR: begin
        m_mtvec = v;
        if (v[1:0] > 2'b01) m_mtvec[1:0] = 2'b00;
      end
      MIE_ADDR:           m_mie = v & IRQ_MASK;
      MIP_ADDR:           m_mip = v & IRQ_MASK;
      MSCRATCH_ADDR:      m_mscratch = v;
      MEPC_ADDR:          m_mepc = v;
      MCAUSE_ADDR:        m_mcause = v;
      MTVAL_ADDR:         m_mtval = v;
      MCOUNTEREN_ADDR:    m_mcounteren = v;
      MCOUNTINHIBIT_ADDR: m_mcountinhibit = v;
      default: ;
    endcase
  endtask

  function automatic csr_addr_t pick_reg(input int sel);
    case (sel % 9)
      0:       return MSTATUS_ADDR;
      1:       return MIE_ADDR;
      2:       return MIP_ADDR;
      3:       return MTVEC_ADDR;
      4:       return MSCRATCH_ADDR;
      5:       return MEPC_ADDR;
      6:       return MCAUSE_ADDR;
      7:       return MTVAL_ADDR;
      default: return MCOUNTEREN_ADDR;
    endcase
  endfunction

  // Registers that a trap never touches
  function automatic csr_addr_t pick_side_reg(input int sel);
    case (sel % 5)
      0:       return MSCRATCH_ADDR;
      1:       return MTVAL_ADDR;
      2:       return MIE_ADDR;
      3:       return MIP_ADDR;
      default: return MCOUNTEREN_ADDR;
    endcase
  endfunction

  function automatic csr_addr_t unknown_addr(input int sel);
    case (sel % 4)
      0:       return 12'h302;
      1:       return 12'h7C0;
      2:       return 12'h123;
      default: return 12'h345;
    endcase
  endfunction

  task automatic issue_csr(input csr_op_t op, input csr_addr_t a, input csr_word_t operand,
                           input priv_level_t priv, output csr_word_t got);
    csr_word_t old_exp;
    csr_word_t new_val;
    logic      wen;
    logic      ill_exp;
    logic      counter;
    old_exp = model_read(a);
    wen     = (op == CSR_RW) || (operand != '0);  // Set and clear of zero do not write
    ill_exp = !model_known(a) || (a[9:8] > priv) || (wen && a[11:10] == 2'b11);
    counter = (a[11:8] == 4'hB);
    @(posedge CLK);
    instr_valid   <= 1'b1;
    instr_op      <= op;
    instr_addr    <= a;
    instr_operand <= operand;
    instr_priv    <= priv;
    @(negedge CLK);
    while (!instr_ready) @(negedge CLK);
    @(posedge CLK);
    instr_valid <= 1'b0;
    @(negedge CLK);
    while (!(resp_valid && resp_ready)) @(negedge CLK);
    got = resp_old;
    assert (resp_illegal == ill_exp) else begin
      err_flag++;
      $display("[ERROR] resp_illegal at %h: got %h expected %h", a, resp_illegal, ill_exp);
    end
    if (!ill_exp && !counter) begin
      assert (resp_old == old_exp) else begin
        err_value++;
        $display("[ERROR] resp_old at %h: got %h expected %h", a, resp_old, old_exp);
      end
    end
    if (!ill_exp && wen) begin
      case (op)
        CSR_RS:  new_val = old_exp | operand;
        CSR_RC:  new_val = old_exp & ~operand;
        default: new_val = operand;
      endcase
      model_write(a, new_val);
    end
  endtask

  task automatic issue_trap(input csr_word_t epc, input csr_word_t cause);
    csr_word_t pc_exp;
    pc_exp = {m_mtvec[31:2], 2'b00};
    if (m_mtvec[1:0] == 2'b01 && cause[31]) pc_exp = pc_exp + (cause << 2);  // Vectored irq
    @(posedge CLK);
    trap_valid <= 1'b1;
    trap_epc   <= epc;
    trap_cause <= cause;
    @(negedge CLK);
    while (!trap_ready) @(negedge CLK);
    @(posedge CLK);
    trap_valid <= 1'b0;
    @(negedge CLK);
    while (!(target_valid && target_ready)) @(negedge CLK);
    assert (target_pc == pc_exp) else begin
      err_target++;
      $display("[ERROR] target_pc for cause %h: got %h expected %h", cause, target_pc, pc_exp);
    end
    m_mepc       = epc;
    m_mcause     = cause;
    m_mstatus[7] = m_mstatus[3];
    m_mstatus[3] = 1'b0;
  endtask

  task automatic read_sweep();
    csr_word_t got;
    for (int i = 0; i < 9; i++) issue_csr(CSR_RS, pick_reg(i), '0, M_MODE, got);
  endtask

  task automatic random_accesses();
    csr_word_t got;
    csr_word_t operand;
    repeat (100) begin
      operand = ($urandom % 8 == 0) ? '0 : $urandom;
      issue_csr(csr_op_t'($urandom % 3), pick_reg($urandom % 9), operand, M_MODE, got);
    end
  endtask

  task automatic illegal_accesses();
    csr_word_t got;
    repeat (40) begin
      case ($urandom % 3)
        0: issue_csr(csr_op_t'($urandom % 3), pick_reg($urandom % 9), $urandom,
                     ($urandom % 2) ? S_MODE : U_MODE, got);
        1: issue_csr(CSR_RW, unknown_addr($urandom % 4), $urandom, M_MODE, got);
        default: issue_csr(CSR_RW, MVENDORID_ADDR + csr_addr_t'($urandom % 4), $urandom,
                           M_MODE, got);
      endcase
    end
  endtask

  task automatic trap_sequence();
    csr_word_t got;
    csr_word_t vec;
    for (int i = 0; i < 30; i++) begin
      if (i % 5 == 0) begin
        vec = $urandom;
        if (i % 10 == 0) vec[1:0] = 2'b01;
        issue_csr(CSR_RW, MTVEC_ADDR, vec, M_MODE, got);
      end
      if ($urandom % 2) issue_csr(CSR_RS, MSTATUS_ADDR, 32'h8, M_MODE, got);  // Set mie
      issue_trap($urandom, $urandom & 32'h8000_001F);
    end
  endtask

  task automatic mixed_traffic();
    fork
      begin : side_instrs
        csr_word_t got;
        repeat (40) begin
          issue_csr(csr_op_t'($urandom % 3), pick_side_reg($urandom % 5), $urandom,
                    M_MODE, got);
        end
      end
      repeat (20) issue_trap($urandom, $urandom & 32'h8000_001F);
    join
  endtask

  task automatic counter_checks();
    csr_word_t first;
    csr_word_t second;
    csr_word_t later;
    issue_csr(CSR_RS, MCYCLE_ADDR, '0, M_MODE, first);
    issue_csr(CSR_RS, MCYCLE_ADDR, '0, M_MODE, second);
    assert (first == second) else begin
      err_counter++;
      $display("[ERROR] mcycle while inhibited: first %h second %h", first, second);
    end
    issue_csr(CSR_RW, MCOUNTINHIBIT_ADDR, '0, M_MODE, later);
    repeat (8) @(posedge CLK);
    issue_csr(CSR_RS, MCYCLE_ADDR, '0, M_MODE, later);
    assert (later > second) else begin
      err_counter++;
      $display("[ERROR] mcycle after enable: got %h, not above %h", later, second);
    end
    issue_csr(CSR_RS, MHARTID_ADDR, '0, M_MODE, later);  // Model expects 5
    issue_csr(CSR_RS, MISA_ADDR, '0, M_MODE, later);
  endtask

  initial begin
    #(OPS * CYCLES_PER_OP * PERIOD);
    $display("Timeout: the tests did not complete in the allowed time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    instr_valid   = 1'b0;
    instr_op      = CSR_RW;
    instr_addr    = '0;
    instr_operand = '0;
    instr_priv    = M_MODE;
    resp_ready    = 1'b0;
    trap_valid    = 1'b0;
    trap_epc      = '0;
    trap_cause    = '0;
    target_ready  = 1'b0;
    inst_ret      = 1'b0;
    err_value     = 0;
    err_flag      = 0;
    err_target    = 0;
    err_counter   = 0;
    m_mstatus       = 32'h0020_1800;  // tw set and mpp at M
    m_mie           = '0;
    m_mip           = '0;
    m_mtvec         = '0;
    m_mscratch      = '0;
    m_mepc          = '0;
    m_mcause        = '0;
    m_mtval         = '0;
    m_mcounteren    = '1;
    m_mcountinhibit = '1;
    void'($urandom(SEED));
    fork
      forever begin
        @(posedge CLK);
        resp_ready   <= ($urandom % 4) != 0;
        target_ready <= ($urandom % 4) != 0;
        inst_ret     <= ($urandom % 2) != 0;
      end
    join_none
    @(posedge nRST);
    @(negedge CLK);
    assert (instr_ready && trap_ready && !resp_valid && !target_valid) else begin
      err_flag++;
      $display("Ready or valid outputs have wrong levels after reset");
    end
    random_accesses();
    read_sweep();
    illegal_accesses();
    read_sweep();
    trap_sequence();
    read_sweep();
    mixed_traffic();
    read_sweep();
    counter_checks();
    repeat (4) @(posedge CLK);
    $display("Errors: old value %0d, illegal flag %0d, target pc %0d, counters %0d",
             err_value, err_flag, err_target, err_counter);
    if (err_value + err_flag + err_target + err_counter == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
verilog/priv_pkg.sv
verilog/machine_csr_file.sv
verilog/csr_op_unit.sv
verilog/trap_sequencer.sv
verilog/csr_arbiter.sv
verilog/priv_unit.sv
tb/tb_clock.sv
tb/tb_priv_unit.sv
